// File: Makefile
# Verilator build and run for the JTAG UART bridge

TOP       ?= jtag_uart_tb
LOG       ?= sim.log
SEED      ?= 82097
VERILATOR ?= verilator
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hw/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
hw/jtag_uart_pkg.sv
hw/char_fifo.sv
hw/jtag_link.sv
hw/jtag_uart_ctrl.sv
hw/jtag_uart_top.sv
dv/jtag_uart_tb.sv

// File: dv/jtag_uart_tb.sv
`timescale 1ns/1ps

module jtag_uart_tb #(
    parameter int SEED = 82097
);

    localparam int DEPTH = 32;
    localparam jtag_uart_pkg::jtag_index_t OWN_INDEX   = 8'd126;
    localparam jtag_uart_pkg::jtag_index_t OTHER_INDEX = 8'd125;
    // reset reads, outbound, inbound, index filtering
    localparam int N_OPS = 2 + 84 + 69 + 8;

    logic                       clk;
    logic                       reset_i;
    logic                       wb_adr_i;
    logic                       wb_stb_i;
    logic                       wb_cyc_i;
    logic                       wb_we_i;
    jtag_uart_pkg::wb_data_t    wb_dat_i;
    jtag_uart_pkg::wb_data_t    wb_dat_o;
    logic                       wb_ack_o;
    jtag_uart_pkg::jtag_req_t   jtag_req_i;
    jtag_uart_pkg::jtag_rsp_t   jtag_rsp_o;

    // reference fifos
    jtag_uart_pkg::char_t       out_q[$];
    jtag_uart_pkg::char_t       in_q[$];

    jtag_uart_pkg::wb_data_t    exp_rdata;
    jtag_uart_pkg::wb_data_t    exp_mask;
    logic                       chk_rdata;
    logic                       exp_rd_valid;
    jtag_uart_pkg::char_t       exp_rd_data;
    jtag_uart_pkg::fill_t       exp_in_space;
    jtag_uart_pkg::fill_t       in_space_d1;
    jtag_uart_pkg::fill_t       in_space_d2;
    int                         seed;
    int                         mismatch_cnt;
    int                         fault_cnt;

    jtag_uart_top u_jtag_uart_top (
        .clk        (clk),
        .reset_i    (reset_i),
        .wb_adr_i   (wb_adr_i),
        .wb_stb_i   (wb_stb_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_we_i    (wb_we_i),
        .wb_dat_i   (wb_dat_i),
        .jtag_req_i (jtag_req_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .jtag_rsp_o (jtag_rsp_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // in_space is registered, so the model value trails by two edges
    always @(posedge clk) begin
        in_space_d1 <= exp_in_space;
        in_space_d2 <= in_space_d1;
    end

    a_reset_quiet: assert property (@(posedge clk)
        reset_i |=> (!wb_ack_o && !jtag_rsp_o.rd_valid))
        else begin
            mismatch_cnt++;
            $display("mismatch after reset: wb_ack_o=%h rd_valid=%h, expected 0",
                $sampled(wb_ack_o), $sampled(jtag_rsp_o.rd_valid));
        end

    a_no_early_ack: assert property (@(posedge clk) disable iff (reset_i)
        $rose(wb_stb_i && wb_cyc_i) |-> !wb_ack_o)
        else begin
            fault_cnt++;
            $display("ack was already high when a new bus request arrived");
        end

    a_ack_latency: assert property (@(posedge clk) disable iff (reset_i)
        $rose(wb_stb_i && wb_cyc_i) |=> wb_ack_o)
        else begin
            fault_cnt++;
            $display("bus request was not acked one cycle after it was seen");
        end

    a_ack_width: assert property (@(posedge clk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o)
        else begin
            fault_cnt++;
            $display("ack stayed high for more than one cycle");
        end

    a_read_data: assert property (@(posedge clk) disable iff (reset_i)
        (wb_ack_o && chk_rdata) |-> ((wb_dat_o & exp_mask) == exp_rdata))
        else begin
            mismatch_cnt++;
            $display("mismatch wb_dat_o: got %h expected %h under mask %h",
                $sampled(wb_dat_o), $sampled(exp_rdata), $sampled(exp_mask));
        end

    a_rd_valid: assert property (@(posedge clk) disable iff (reset_i)
        jtag_req_i.rd |=> (jtag_rsp_o.rd_valid == exp_rd_valid))
        else begin
            mismatch_cnt++;
            $display("mismatch rd_valid: got %h expected %h",
                $sampled(jtag_rsp_o.rd_valid), $sampled(exp_rd_valid));
        end

    a_rd_data: assert property (@(posedge clk) disable iff (reset_i)
        (jtag_req_i.rd && exp_rd_valid) |=> (jtag_rsp_o.rd_data == exp_rd_data))
        else begin
            mismatch_cnt++;
            $display("mismatch rd_data: got %h expected %h",
                $sampled(jtag_rsp_o.rd_data), $sampled(exp_rd_data));
        end

    a_no_spurious_valid: assert property (@(posedge clk) disable iff (reset_i)
        !jtag_req_i.rd |=> !jtag_rsp_o.rd_valid)
        else begin
            fault_cnt++;
            $display("rd_valid pulsed without a host read");
        end

    a_in_space: assert property (@(posedge clk) disable iff (reset_i)
        jtag_rsp_o.in_space == in_space_d2)
        else begin
            mismatch_cnt++;
            $display("mismatch in_space: got %h expected %h",
                $sampled(jtag_rsp_o.in_space), $sampled(in_space_d2));
        end

    function automatic jtag_uart_pkg::char_t next_char();
        return jtag_uart_pkg::char_t'($random(seed));
    endfunction

    // master waits for ack, then drops the strobe
    task automatic finish_bus_cycle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wb_ack_o && waited < 8) begin
            waited++;
            @(negedge clk);
        end
        if (!wb_ack_o) begin
            fault_cnt++;
            $display("bus cycle ended without ack");
        end
        wb_stb_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input jtag_uart_pkg::char_t c);
        @(negedge clk);
        chk_rdata = 1'b0;
        if (out_q.size() < DEPTH) begin
            out_q.push_back(c);
        end
        wb_adr_i = jtag_uart_pkg::REG_DATA;
        wb_we_i  = 1'b1;
        wb_dat_i = {24'($random(seed)), c};
        wb_stb_i = 1'b1;
        wb_cyc_i = 1'b1;
        finish_bus_cycle();
    endtask

    task automatic bus_read(input logic adr);
        @(negedge clk);
        chk_rdata = 1'b1;
        exp_mask  = '1;
        if (adr == jtag_uart_pkg::REG_CTRL) begin
            exp_rdata = {jtag_uart_pkg::fill_t'(DEPTH - out_q.size()), 16'h0000};
        end else if (in_q.size() != 0) begin
            // count is taken before the pop
            exp_rdata = {jtag_uart_pkg::fill_t'(in_q.size()), 1'b1, 7'h00, in_q[0]};
            void'(in_q.pop_front());
            exp_in_space = jtag_uart_pkg::fill_t'(DEPTH - in_q.size());
        end else begin
            exp_rdata = '0;
            exp_mask  = 32'hffff_ff00;
        end
        wb_adr_i = adr;
        wb_we_i  = 1'b0;
        wb_stb_i = 1'b1;
        wb_cyc_i = 1'b1;
        finish_bus_cycle();
    endtask

    task automatic host_write(input jtag_uart_pkg::jtag_index_t index,
                              input jtag_uart_pkg::char_t c);
        @(negedge clk);
        if (index == OWN_INDEX && in_q.size() < DEPTH) begin
            in_q.push_back(c);
            exp_in_space = jtag_uart_pkg::fill_t'(DEPTH - in_q.size());
        end
        jtag_req_i.index = index;
        jtag_req_i.wr    = 1'b1;
        jtag_req_i.rd    = 1'b0;
        jtag_req_i.data  = c;
        @(negedge clk);
        jtag_req_i.wr = 1'b0;
    endtask

    task automatic host_read(input jtag_uart_pkg::jtag_index_t index);
        @(negedge clk);
        exp_rd_valid = (index == OWN_INDEX) && (out_q.size() != 0);
        if (exp_rd_valid) begin
            exp_rd_data = out_q.pop_front();
        end
        jtag_req_i.index = index;
        jtag_req_i.wr    = 1'b0;
        jtag_req_i.rd    = 1'b1;
        jtag_req_i.data  = '0;
        @(negedge clk);
        jtag_req_i.rd = 1'b0;
    endtask

    initial begin
        seed         = SEED;
        mismatch_cnt = 0;
        fault_cnt    = 0;
        reset_i      = 1'b1;
        wb_adr_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_cyc_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_dat_i     = '0;
        jtag_req_i   = '0;
        chk_rdata    = 1'b0;
        exp_rdata    = '0;
        exp_mask     = '0;
        exp_rd_valid = 1'b0;
        exp_rd_data  = '0;
        exp_in_space = jtag_uart_pkg::fill_t'(DEPTH);
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // reset state
        bus_read(jtag_uart_pkg::REG_CTRL);
        bus_read(jtag_uart_pkg::REG_DATA);

        // outbound path overfilled past 32 so later writes drop
        for (int i = 0; i < 40; i++) begin
            bus_write(next_char());
            if (i % 10 == 9) begin
                host_read(OWN_INDEX);
            end
            if (i % 8 == 7) begin
                bus_read(jtag_uart_pkg::REG_CTRL);
            end
        end
        bus_read(jtag_uart_pkg::REG_CTRL);
        repeat (33) host_read(OWN_INDEX);
        bus_read(jtag_uart_pkg::REG_CTRL);

        // inbound with two writes past full and three reads past empty
        repeat (34) host_write(OWN_INDEX, next_char());
        repeat (35) bus_read(jtag_uart_pkg::REG_DATA);

        // foreign index leaves both fifos alone
        bus_write(next_char());
        bus_write(next_char());
        host_write(OTHER_INDEX, next_char());
        host_read(OTHER_INDEX);
        bus_read(jtag_uart_pkg::REG_DATA);
        repeat (3) host_read(OWN_INDEX);

        repeat (3) @(negedge clk);
        $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fault_cnt);
        if (mismatch_cnt == 0 && fault_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // roughly four cycles per operation plus slack
    initial begin
        #((N_OPS * 4 + 50) * 100);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

// File: hw/char_fifo.sv
`timescale 1ns/1ps

module char_fifo #(
    parameter int BUFF_AW = 5
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       push_i,
    input  jtag_uart_pkg::char_t       push_data_i,
    input  logic                       pop_i,
    output jtag_uart_pkg::char_t       pop_data_o,
    output logic [BUFF_AW:0]           level_o,
    output logic [BUFF_AW:0]           space_o
);

    localparam logic [BUFF_AW:0] DEPTH = {1'b1, {BUFF_AW{1'b0}}};

    jtag_uart_pkg::char_t mem [2**BUFF_AW];

    logic [BUFF_AW-1:0] wr_ptr;
    logic [BUFF_AW-1:0] rd_ptr;
    logic [BUFF_AW:0]   count;
    logic               push_ok;
    logic               pop_ok;

    // full push and empty pop are dropped here
    assign push_ok = push_i && (count != DEPTH);
    assign pop_ok  = pop_i && (count != '0);

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // oldest entry, shown without a read cycle
    assign pop_data_o = mem[rd_ptr];
    assign level_o    = count;
    assign space_o    = DEPTH - count;

    a_level_bound: assert property (@(posedge clk) disable iff (reset_i)
        count <= DEPTH);

endmodule

// File: hw/jtag_link.sv
`timescale 1ns/1ps

module jtag_link #(
    parameter jtag_uart_pkg::jtag_index_t JTAG_INDEX = 8'd126,
    parameter int                         BUFF_AW    = 5
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  jtag_uart_pkg::jtag_req_t   jtag_req_i,
    input  jtag_uart_pkg::char_t       out_data_i,
    input  logic [BUFF_AW:0]           out_level_i,
    input  logic [BUFF_AW:0]           in_space_i,
    output jtag_uart_pkg::jtag_rsp_t   jtag_rsp_o,
    output logic                       in_push_o,
    output jtag_uart_pkg::char_t       in_data_o,
    output logic                       out_pop_o
);

    logic                  hit;
    logic                  rd_valid_q;
    jtag_uart_pkg::char_t  rd_data_q;
    jtag_uart_pkg::fill_t  in_space_q;

    // requests for other chain positions are ignored
    assign hit = (jtag_req_i.index == JTAG_INDEX);

    assign in_push_o = hit && jtag_req_i.wr;
    assign in_data_o = jtag_req_i.data;
    assign out_pop_o = hit && jtag_req_i.rd;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= out_pop_o && (out_level_i != '0);
        end
    end

    // character and space samples, no reset
    always_ff @(posedge clk) begin
        if (out_pop_o) begin
            rd_data_q <= out_data_i;
        end
        in_space_q <= jtag_uart_pkg::fill_t'(in_space_i);
    end

    assign jtag_rsp_o.rd_valid = rd_valid_q;
    assign jtag_rsp_o.rd_data  = rd_data_q;
    assign jtag_rsp_o.in_space = in_space_q;

    a_single_strobe: assert property (@(posedge clk) disable iff (reset_i)
        !(jtag_req_i.wr && jtag_req_i.rd));

endmodule

// File: hw/jtag_uart_ctrl.sv
`timescale 1ns/1ps

module jtag_uart_ctrl #(
    parameter int BUFF_AW = 5
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       wb_adr_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_we_i,
    input  jtag_uart_pkg::wb_data_t    wb_dat_i,
    input  jtag_uart_pkg::char_t       in_data_i,
    input  logic [BUFF_AW:0]           in_level_i,
    input  logic [BUFF_AW:0]           out_space_i,
    output jtag_uart_pkg::wb_data_t    wb_dat_o,
    output logic                       wb_ack_o,
    output logic                       out_push_o,
    output jtag_uart_pkg::char_t       out_data_o,
    output logic                       in_pop_o
);

    jtag_uart_pkg::wb_state_e state_q;
    jtag_uart_pkg::wb_state_e state_d;

    logic                     req;
    logic                     accept;
    jtag_uart_pkg::wb_data_t  rd_word;
    jtag_uart_pkg::wb_data_t  rd_word_q;

    assign req    = wb_stb_i && wb_cyc_i;
    assign accept = (state_q == jtag_uart_pkg::WB_IDLE) && req;

    // one ack per request, then one idle cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            jtag_uart_pkg::WB_IDLE: begin
                if (req) begin
                    state_d = jtag_uart_pkg::WB_ACK;
                end
            end
            jtag_uart_pkg::WB_ACK: begin
                state_d = jtag_uart_pkg::WB_IDLE;
            end
            default: begin
                state_d = jtag_uart_pkg::WB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= jtag_uart_pkg::WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign wb_ack_o = (state_q == jtag_uart_pkg::WB_ACK);

    // fifo side effects land on the edge that raises ack
    assign out_push_o = accept && wb_we_i && (wb_adr_i == jtag_uart_pkg::REG_DATA);
    assign in_pop_o   = accept && !wb_we_i && (wb_adr_i == jtag_uart_pkg::REG_DATA);
    assign out_data_o = wb_dat_i[7:0];

    // read word from the register map
    always_comb begin
        rd_word = '0;
        if (wb_adr_i == jtag_uart_pkg::REG_CTRL) begin
            rd_word[jtag_uart_pkg::COUNT_LSB +: 16] = jtag_uart_pkg::fill_t'(out_space_i);
        end else begin
            rd_word[jtag_uart_pkg::COUNT_LSB +: 16] = jtag_uart_pkg::fill_t'(in_level_i);
            rd_word[jtag_uart_pkg::RVALID_BIT]      = (in_level_i != '0);
            rd_word[7:0]                            = in_data_i;
        end
    end

    // captured before the pop, held while ack is high
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_word_q <= rd_word;
        end
    end

    assign wb_dat_o = rd_word_q;

    a_ack_single: assert property (@(posedge clk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o);

    a_fifo_op_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        (out_push_o || in_pop_o) |-> (wb_stb_i && wb_cyc_i));

endmodule

// File: hw/jtag_uart_pkg.sv
package jtag_uart_pkg;

    // bus side
    typedef logic [31:0] wb_data_t;
    typedef logic [7:0]  char_t;

    // register count fields, fifo levels zero-extend into this
    typedef logic [15:0] fill_t;

    // selects one bridge on the chain
    typedef logic [7:0]  jtag_index_t;

    // register map, one address bit
    localparam logic REG_DATA = 1'b0;
    localparam logic REG_CTRL = 1'b1;

    localparam int RVALID_BIT = 15;
    localparam int COUNT_LSB  = 16;

    // host request, wr and rd are one-cycle strobes
    typedef struct packed {
        jtag_index_t index;
        logic        wr;
        logic        rd;
        char_t       data;
    } jtag_req_t;

    typedef struct packed {
        logic  rd_valid;
        char_t rd_data;
        fill_t in_space;
    } jtag_rsp_t;

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

endpackage

// File: hw/jtag_uart_top.sv
`timescale 1ns/1ps

module jtag_uart_top #(
    parameter int                         BUFF_AW    = 5,
    parameter jtag_uart_pkg::jtag_index_t JTAG_INDEX = 8'd126
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       wb_adr_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_we_i,
    input  jtag_uart_pkg::wb_data_t    wb_dat_i,
    input  jtag_uart_pkg::jtag_req_t   jtag_req_i,
    output jtag_uart_pkg::wb_data_t    wb_dat_o,
    output logic                       wb_ack_o,
    output jtag_uart_pkg::jtag_rsp_t   jtag_rsp_o
);

    // bus to host
    logic                  out_push;
    jtag_uart_pkg::char_t  out_push_data;
    logic                  out_pop;
    jtag_uart_pkg::char_t  out_pop_data;
    logic [BUFF_AW:0]      out_level;
    logic [BUFF_AW:0]      out_space;

    // host to bus
    logic                  in_push;
    jtag_uart_pkg::char_t  in_push_data;
    logic                  in_pop;
    jtag_uart_pkg::char_t  in_pop_data;
    logic [BUFF_AW:0]      in_level;
    logic [BUFF_AW:0]      in_space;

    jtag_uart_ctrl #(
        .BUFF_AW (BUFF_AW)
    ) u_ctrl (
        .clk         (clk),
        .reset_i     (reset_i),
        .wb_adr_i    (wb_adr_i),
        .wb_stb_i    (wb_stb_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_we_i     (wb_we_i),
        .wb_dat_i    (wb_dat_i),
        .in_data_i   (in_pop_data),
        .in_level_i  (in_level),
        .out_space_i (out_space),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .out_push_o  (out_push),
        .out_data_o  (out_push_data),
        .in_pop_o    (in_pop)
    );

    jtag_link #(
        .JTAG_INDEX (JTAG_INDEX),
        .BUFF_AW    (BUFF_AW)
    ) u_link (
        .clk         (clk),
        .reset_i     (reset_i),
        .jtag_req_i  (jtag_req_i),
        .out_data_i  (out_pop_data),
        .out_level_i (out_level),
        .in_space_i  (in_space),
        .jtag_rsp_o  (jtag_rsp_o),
        .in_push_o   (in_push),
        .in_data_o   (in_push_data),
        .out_pop_o   (out_pop)
    );

    char_fifo #(
        .BUFF_AW (BUFF_AW)
    ) u_out_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (out_push),
        .push_data_i (out_push_data),
        .pop_i       (out_pop),
        .pop_data_o  (out_pop_data),
        .level_o     (out_level),
        .space_o     (out_space)
    );

    char_fifo #(
        .BUFF_AW (BUFF_AW)
    ) u_in_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (in_push),
        .push_data_i (in_push_data),
        .pop_i       (in_pop),
        .pop_data_o  (in_pop_data),
        .level_o     (in_level),
        .space_o     (in_space)
    );

endmodule
